// File: cache_geom_pkg.sv
`default_nettype none

package cache_geom_pkg;

    // address split: tag | index | offset
    localparam int TAG_W      = 20;
    localparam int INDEX_W    = 7;
    localparam int OFFSET_W   = 5;

    localparam int LINE_BYTES = 32;
    localparam int LINE_WORDS = 8;
    localparam int NUM_SETS   = 128;
    localparam int NUM_WAYS   = 2;

    typedef logic [TAG_W-1:0]                tag_t;
    typedef logic [INDEX_W-1:0]              index_t;
    typedef logic [OFFSET_W-1:0]             offset_t;
    typedef logic [31:0]                     word_t;
    typedef logic [3:0]                      strb_t;
    typedef logic [LINE_BYTES*8-1:0]         line_t;
    typedef logic [LINE_BYTES-1:0]           line_strb_t;
    typedef logic [$clog2(LINE_WORDS)-1:0]   beat_t;
    typedef logic [$clog2(NUM_WAYS)-1:0]     way_t;
    typedef logic [NUM_WAYS-1:0]             way_vec_t;

    localparam logic OP_READ  = 1'b0;
    localparam logic OP_WRITE = 1'b1;

    // one processor access as presented on the request port
    typedef struct packed {
        logic       op;
        logic       uncached;
        logic [1:0] size;
        tag_t       tag;
        index_t     index;
        offset_t    offset;
        strb_t      wstrb;
        word_t      wdata;
    } cpu_req_t;

endpackage

`default_nettype wire

// File: mem_bus_pkg.sv
`default_nettype none

package mem_bus_pkg;

    typedef logic [2:0] mem_type_t;

    // whole-line transfer; uncached ones carry {1'b0, size}
    localparam mem_type_t TYPE_LINE = 3'b100;

    typedef struct packed {
        mem_type_t   req_type;
        logic [31:0] addr;
    } mem_rd_req_t;

    // one returned beat
    typedef struct packed {
        logic                  valid;
        logic                  last;
        cache_geom_pkg::word_t data;
    } mem_ret_t;

    // uncached writes use the low word of data only
    typedef struct packed {
        mem_type_t             req_type;
        logic [31:0]           addr;
        cache_geom_pkg::strb_t wstrb;
        cache_geom_pkg::line_t data;
    } mem_wr_req_t;

endpackage

`default_nettype wire

// File: cache_tag_store.sv
`default_nettype none

module cache_tag_store (
    input  wire                             clk,
    input  wire                             resetn,
    input  wire                             rd_en,
    input  wire cache_geom_pkg::index_t     rd_index,
    input  wire cache_geom_pkg::tag_t       cmp_tag,
    input  wire cache_geom_pkg::way_t       victim,
    output cache_geom_pkg::way_vec_t        hit,
    output cache_geom_pkg::tag_t            victim_tag,
    output logic                            victim_dirty,
    input  wire                             wr_en,
    input  wire cache_geom_pkg::way_t       wr_way,
    input  wire cache_geom_pkg::index_t     wr_index,
    input  wire cache_geom_pkg::tag_t       wr_tag,
    input  wire                             wr_dirty
);
    import cache_geom_pkg::*;

    tag_t [NUM_WAYS-1:0] way_tag;
    way_vec_t            way_dirty;

    for (genvar w = 0; w < NUM_WAYS; w++) begin : g_way
        tag_t                tags [NUM_SETS];
        logic                dirty [NUM_SETS];
        logic [NUM_SETS-1:0] valid_bits;
        tag_t                tag_q;
        logic                valid_q;
        logic                dirty_q;
        logic                wr_sel;

        assign wr_sel = wr_en && (wr_way == way_t'(w));

        // valid only ever sets; lines are never invalidated
        always_ff @(posedge clk) begin
            if (!resetn) begin
                valid_bits <= '0;
            end else if (wr_sel) begin
                valid_bits[wr_index] <= 1'b1;
            end
        end

        always_ff @(posedge clk) begin
            if (wr_sel) begin
                tags[wr_index]  <= wr_tag;
                dirty[wr_index] <= wr_dirty;
            end
        end

        // registered lookup, one cycle after the read strobe
        always_ff @(posedge clk) begin
            if (!resetn) begin
                valid_q <= 1'b0;
            end else if (rd_en) begin
                valid_q <= valid_bits[rd_index];
            end
        end

        always_ff @(posedge clk) begin
            if (rd_en) begin
                tag_q   <= tags[rd_index];
                dirty_q <= dirty[rd_index];
            end
        end

        assign hit[w]       = valid_q && (tag_q == cmp_tag);
        assign way_tag[w]   = tag_q;
        assign way_dirty[w] = valid_q && dirty_q;
    end

    assign victim_tag   = way_tag[victim];
    assign victim_dirty = way_dirty[victim];

    // a refill only allocates on a miss, so one tag never sits in both ways
    assert property (@(posedge clk) disable iff (!resetn) $onehot0(hit));

endmodule

`default_nettype wire

// File: cache_data_store.sv
`default_nettype none

module cache_data_store (
    input  wire                              clk,
    input  wire                              rd_en,
    input  wire cache_geom_pkg::index_t      rd_index,
    output cache_geom_pkg::line_t [cache_geom_pkg::NUM_WAYS-1:0] lines,
    input  wire                              wr_en,
    input  wire cache_geom_pkg::way_t        wr_way,
    input  wire cache_geom_pkg::index_t      wr_index,
    input  wire cache_geom_pkg::line_t       wr_base,
    input  wire cache_geom_pkg::line_t       wr_line,
    input  wire cache_geom_pkg::line_strb_t  wr_mask
);
    import cache_geom_pkg::*;

    line_t merged;

    // bytes under the mask come from wr_line, the rest from wr_base
    always_comb begin
        for (int b = 0; b < LINE_BYTES; b++) begin
            if (wr_mask[b]) begin
                merged[8*b +: 8] = wr_line[8*b +: 8];
            end else begin
                merged[8*b +: 8] = wr_base[8*b +: 8];
            end
        end
    end

    for (genvar w = 0; w < NUM_WAYS; w++) begin : g_way
        line_t mem [NUM_SETS];
        line_t rd_q;

        always_ff @(posedge clk) begin
            if (wr_en && (wr_way == way_t'(w))) begin
                mem[wr_index] <= merged;
            end
        end

        // both ways are read so the hit way can be picked late
        always_ff @(posedge clk) begin
            if (rd_en) begin
                rd_q <= mem[rd_index];
            end
        end

        assign lines[w] = rd_q;
    end

endmodule

`default_nettype wire

// File: cache_refill_buffer.sv
`default_nettype none

module cache_refill_buffer (
    input  wire                         clk,
    input  wire                         resetn,
    input  wire mem_bus_pkg::mem_ret_t  ret,
    output cache_geom_pkg::line_t       line,
    output cache_geom_pkg::beat_t       count
);
    import cache_geom_pkg::*;

    line_t line_q;

    // beats come in word order, so count is also the word slot
    always_ff @(posedge clk) begin
        if (ret.valid) begin
            line_q[{count, 5'd0} +: 32] <= ret.data;
        end
    end

    // current beat already folded in, so the full line is ready on last
    always_comb begin
        line = line_q;
        if (ret.valid) begin
            line[{count, 5'd0} +: 32] = ret.data;
        end
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            count <= '0;
        end else if (ret.valid) begin
            count <= ret.last ? beat_t'(0) : count + 1'b1;
        end
    end

    // the bus must close a line burst on its final word
    assert property (@(posedge clk) disable iff (!resetn)
        (ret.valid && (count == beat_t'(LINE_WORDS - 1))) |-> ret.last);

endmodule

`default_nettype wire

// File: cache_ctrl.sv
`default_nettype none

module cache_ctrl (
    input  wire                              clk,
    input  wire                              resetn,
    input  wire                              req_valid,
    input  wire cache_geom_pkg::cpu_req_t    req,
    output logic                             addr_ok,
    output logic                             data_ok,
    output cache_geom_pkg::word_t            rdata,
    output logic                             store_rd_en,
    output cache_geom_pkg::index_t           store_rd_index,
    output cache_geom_pkg::tag_t             cmp_tag,
    input  wire cache_geom_pkg::way_vec_t    hit,
    output cache_geom_pkg::way_t             victim,
    input  wire cache_geom_pkg::tag_t        victim_tag,
    input  wire                              victim_dirty,
    input  wire cache_geom_pkg::line_t [cache_geom_pkg::NUM_WAYS-1:0] lines,
    output logic                             tag_wr_en,
    output logic                             data_wr_en,
    output cache_geom_pkg::way_t             wr_way,
    output cache_geom_pkg::index_t           wr_index,
    output cache_geom_pkg::tag_t             wr_tag,
    output logic                             wr_dirty,
    output cache_geom_pkg::line_t            wr_base,
    output cache_geom_pkg::line_t            wr_line,
    output cache_geom_pkg::line_strb_t       wr_mask,
    input  wire cache_geom_pkg::line_t       buf_line,
    input  wire cache_geom_pkg::beat_t       buf_count,
    input  wire mem_bus_pkg::mem_ret_t       ret,
    output logic                             rd_req,
    output mem_bus_pkg::mem_rd_req_t         rd,
    input  wire                              rd_rdy,
    output logic                             wr_req,
    output mem_bus_pkg::mem_wr_req_t         wr,
    input  wire                              wr_rdy
);
    import cache_geom_pkg::*;
    import mem_bus_pkg::*;

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_LOOKUP,
        ST_MISS,
        ST_WRITEBACK,
        ST_REFILL
    } state_t;

    state_t    state;
    state_t    state_nxt;
    cpu_req_t  req_r;
    way_t      victim_ptr;
    logic      rd_sent;
    beat_t     req_word;
    way_t      hit_way;
    logic      cached_hit;
    logic      read_hit;
    logic      write_hit;
    logic      line_fill;
    logic      ret_last;
    line_t     rd_line;
    mem_type_t word_type;

    assign req_word   = req_r.offset[OFFSET_W-1:2];
    assign hit_way    = hit[1];
    assign cached_hit = (state == ST_LOOKUP) && (|hit) && !req_r.uncached;
    assign read_hit   = cached_hit && (req_r.op == OP_READ);
    assign write_hit  = cached_hit && (req_r.op == OP_WRITE);
    assign ret_last   = ret.valid && ret.last;
    assign line_fill  = (state == ST_REFILL) && ret_last && !req_r.uncached;

    // a read hit frees the pipe in its own lookup cycle
    assign addr_ok        = req_valid && ((state == ST_IDLE) || read_hit);
    assign store_rd_en    = addr_ok;
    assign store_rd_index = req.index;
    assign cmp_tag        = req_r.tag;
    assign victim         = victim_ptr;

    always_ff @(posedge clk) begin
        if (addr_ok) begin
            req_r <= req;
        end
    end

    always_comb begin
        state_nxt = state;
        case (state)
            ST_IDLE:      if (addr_ok) state_nxt = ST_LOOKUP;
            ST_LOOKUP: begin
                if (!cached_hit) begin
                    state_nxt = ST_MISS;
                end else if (!addr_ok) begin
                    state_nxt = ST_IDLE;
                end
            end
            ST_MISS: begin
                if (req_r.uncached ? (req_r.op == OP_WRITE) : victim_dirty) begin
                    state_nxt = ST_WRITEBACK;
                end else begin
                    state_nxt = ST_REFILL;
                end
            end
            ST_WRITEBACK: if (wr_rdy) state_nxt = req_r.uncached ? ST_IDLE : ST_REFILL;
            ST_REFILL:    if (ret_last) state_nxt = ST_IDLE;
            default:      state_nxt = ST_IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            state      <= ST_IDLE;
            victim_ptr <= '0;
            rd_sent    <= 1'b0;
        end else begin
            state <= state_nxt;
            if (line_fill) begin
                victim_ptr <= ~victim_ptr;
            end
            if (rd_req && rd_rdy) begin
                rd_sent <= 1'b1;
            end else if (ret_last) begin
                rd_sent <= 1'b0;
            end
        end
    end

    // writes answer at lookup, reads at the hit or the critical beat
    assign data_ok = ((state == ST_LOOKUP) && (req_r.op == OP_WRITE)) || read_hit ||
                     ((state == ST_REFILL) && (req_r.op == OP_READ) && ret.valid &&
                      (req_r.uncached ? ret.last : (buf_count == req_word)));

    assign rd_line = (state == ST_LOOKUP) ? lines[hit_way] : buf_line;
    assign rdata   = req_r.uncached ? ret.data : rd_line[{req_word, 5'd0} +: 32];

    // same merge rule for a write hit and a write-allocate refill
    assign tag_wr_en  = write_hit || line_fill;
    assign data_wr_en = write_hit || line_fill;
    assign wr_way     = line_fill ? victim_ptr : hit_way;
    assign wr_index   = req_r.index;
    assign wr_tag     = req_r.tag;
    assign wr_dirty   = (req_r.op == OP_WRITE);
    assign wr_base    = line_fill ? buf_line : lines[hit_way];
    assign wr_line    = {LINE_WORDS{req_r.wdata}};
    assign wr_mask    = (req_r.op == OP_WRITE) ?
                        (line_strb_t'(req_r.wstrb) << {req_word, 2'b00}) : '0;

    assign word_type = {1'b0, req_r.size};
    assign rd_req    = (state == ST_REFILL) && !rd_sent;
    assign wr_req    = (state == ST_WRITEBACK);

    always_comb begin
        if (req_r.uncached) begin
            rd.req_type = word_type;
            rd.addr     = {req_r.tag, req_r.index, req_r.offset};
            wr.req_type = word_type;
            wr.addr     = {req_r.tag, req_r.index, req_r.offset};
            wr.wstrb    = req_r.wstrb;
            wr.data     = line_t'(req_r.wdata);
        end else begin
            rd.req_type = TYPE_LINE;
            rd.addr     = {req_r.tag, req_r.index, {OFFSET_W{1'b0}}};
            wr.req_type = TYPE_LINE;
            wr.addr     = {victim_tag, req_r.index, {OFFSET_W{1'b0}}};
            wr.wstrb    = 4'b1111;
            wr.data     = lines[victim_ptr];
        end
    end

    // bus requests hold steady until taken
    assert property (@(posedge clk) disable iff (!resetn)
        (rd_req && !rd_rdy) |=> (rd_req && $stable(rd)));
    assert property (@(posedge clk) disable iff (!resetn)
        (wr_req && !wr_rdy) |=> (wr_req && $stable(wr)));

endmodule

`default_nettype wire

// File: cache_top.sv
`default_nettype none

module cache_top (
    input  wire                              clk,
    input  wire                              resetn,
    input  wire                              req_valid,
    input  wire cache_geom_pkg::cpu_req_t    req,
    output logic                             addr_ok,
    output logic                             data_ok,
    output cache_geom_pkg::word_t            rdata,
    output logic                             rd_req,
    output mem_bus_pkg::mem_rd_req_t         rd,
    input  wire                              rd_rdy,
    input  wire mem_bus_pkg::mem_ret_t       ret,
    output logic                             wr_req,
    output mem_bus_pkg::mem_wr_req_t         wr,
    input  wire                              wr_rdy
);
    import cache_geom_pkg::*;

    // store read side
    logic                 store_rd_en;
    index_t               store_rd_index;
    tag_t                 cmp_tag;
    way_vec_t             hit;
    way_t                 victim;
    tag_t                 victim_tag;
    logic                 victim_dirty;
    line_t [NUM_WAYS-1:0] lines;

    // store write side
    logic                 tag_wr_en;
    logic                 data_wr_en;
    way_t                 wr_way;
    index_t               wr_index;
    tag_t                 wr_tag;
    logic                 wr_dirty;
    line_t                wr_base;
    line_t                wr_line;
    line_strb_t           wr_mask;

    line_t                buf_line;
    beat_t                buf_count;

    cache_tag_store u_tag_store (
        .clk, .resetn,
        .rd_en(store_rd_en), .rd_index(store_rd_index), .cmp_tag, .victim,
        .hit, .victim_tag, .victim_dirty,
        .wr_en(tag_wr_en), .wr_way, .wr_index, .wr_tag, .wr_dirty
    );

    cache_data_store u_data_store (
        .clk, .rd_en(store_rd_en), .rd_index(store_rd_index), .lines,
        .wr_en(data_wr_en), .wr_way, .wr_index, .wr_base, .wr_line, .wr_mask
    );

    cache_refill_buffer u_refill_buffer (
        .clk, .resetn, .ret, .line(buf_line), .count(buf_count)
    );

    cache_ctrl u_ctrl (
        .clk, .resetn, .req_valid, .req, .addr_ok, .data_ok, .rdata,
        .store_rd_en, .store_rd_index, .cmp_tag, .hit, .victim, .victim_tag,
        .victim_dirty, .lines, .tag_wr_en, .data_wr_en, .wr_way, .wr_index,
        .wr_tag, .wr_dirty, .wr_base, .wr_line, .wr_mask,
        .buf_line, .buf_count,
        .ret, .rd_req, .rd, .rd_rdy, .wr_req, .wr, .wr_rdy
    );

endmodule

`default_nettype wire

// File: cache_tb_mem.sv
`default_nettype none

module cache_tb_mem (
    input  wire                               clk,
    input  wire                               rd_req,
    input  wire mem_bus_pkg::mem_rd_req_t     rd,
    output logic                              rd_rdy,
    output mem_bus_pkg::mem_ret_t             ret,
    input  wire                               wr_req,
    input  wire mem_bus_pkg::mem_wr_req_t     wr,
    output logic                              wr_rdy
);
    timeunit 1ns;
    timeprecision 1ns;
    import cache_geom_pkg::*;
    import mem_bus_pkg::*;

    // words written so far; others follow the fill rule
    word_t       store [logic [29:0]];
    logic [15:0] lfsr = 16'd36264;

    int          rd_count = 0;
    int          wr_count = 0;
    int          done_count = 0;
    mem_type_t   rd_type_log [64];
    logic [31:0] rd_addr_log [64];
    mem_type_t   wr_type_log [64];
    logic [31:0] wr_addr_log [64];
    strb_t       wr_strb_log [64];
    line_t       wr_data_log [64];

    function automatic word_t read_word(input logic [29:0] wi);
        return store.exists(wi) ? store[wi] : ({wi, 2'b00} ^ 32'h5A5A0000);
    endfunction

    // galois lfsr, one step per bit
    function automatic int draw_delay();
        int d;
        d = 0;
        for (int i = 0; i < 2; i++) begin
            d = (d << 1) | lfsr[0];
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 16'hB400) : (lfsr >> 1);
        end
        return d;
    endfunction

    initial begin
        logic        take_rd;
        logic        take_wr;
        logic        rd_seen;
        logic        wr_seen;
        int          rd_wait;
        int          wr_wait;
        int          beats_left;
        logic [29:0] beat_addr;
        word_t       w;
        rd_rdy = 1'b0;
        wr_rdy = 1'b0;
        ret = '0;
        rd_wait = -1;
        wr_wait = -1;
        beats_left = 0;
        beat_addr = '0;
        forever begin
            // sample mid-cycle, act just after the next edge
            @(negedge clk);
            take_rd = rd_req && rd_rdy;
            take_wr = wr_req && wr_rdy;
            rd_seen = rd_req;
            wr_seen = wr_req;
            @(posedge clk);
            #1;
            if (take_rd) begin
                rd_rdy = 1'b0;
                rd_type_log[rd_count] = rd.req_type;
                rd_addr_log[rd_count] = rd.addr;
                rd_count++;
                beats_left = (rd.req_type == TYPE_LINE) ? LINE_WORDS : 1;
                beat_addr = (rd.req_type == TYPE_LINE) ? {rd.addr[31:5], 3'b000}
                                                       : rd.addr[31:2];
            end else if (rd_seen) begin
                if (rd_wait < 0) rd_wait = draw_delay();
                if (rd_wait == 0) rd_rdy = 1'b1;
                rd_wait = (rd_wait == 0) ? -1 : rd_wait - 1;
            end
            if (take_wr) begin
                wr_rdy = 1'b0;
                wr_type_log[wr_count] = wr.req_type;
                wr_addr_log[wr_count] = wr.addr;
                wr_strb_log[wr_count] = wr.wstrb;
                wr_data_log[wr_count] = wr.data;
                wr_count++;
                if (wr.req_type == TYPE_LINE) begin
                    for (int k = 0; k < LINE_WORDS; k++) begin
                        store[{wr.addr[31:5], 3'(k)}] = wr.data[32*k +: 32];
                    end
                end else begin
                    w = read_word(wr.addr[31:2]);
                    for (int b = 0; b < 4; b++) begin
                        if (wr.wstrb[b]) w[8*b +: 8] = wr.data[8*b +: 8];
                    end
                    store[wr.addr[31:2]] = w;
                end
            end else if (wr_seen) begin
                if (wr_wait < 0) wr_wait = draw_delay();
                if (wr_wait == 0) wr_rdy = 1'b1;
                wr_wait = (wr_wait == 0) ? -1 : wr_wait - 1;
            end
            if (beats_left > 0) begin
                ret = '{valid: 1'b1, last: (beats_left == 1), data: read_word(beat_addr)};
                beat_addr++;
                beats_left--;
                if (beats_left == 0) done_count++;
            end else begin
                ret = '0;
            end
        end
    end

endmodule

`default_nettype wire

// File: cache_tb.sv
`default_nettype none

module cache_tb;
    timeunit 1ns;
    timeprecision 1ns;
    import cache_geom_pkg::*;
    import mem_bus_pkg::*;

    localparam int NUM_ACCESSES = 28;

    logic        clk = 1'b0;
    logic        resetn;
    logic        req_valid;
    cpu_req_t    req;
    logic        addr_ok;
    logic        data_ok;
    word_t       rdata;
    logic        rd_req;
    mem_rd_req_t rd;
    logic        rd_rdy;
    mem_ret_t    ret;
    logic        wr_req;
    mem_wr_req_t wr;
    logic        wr_rdy;

    int          errors = 0;
    logic [15:0] lfsr = 16'd36264;

    // reference: byte shadow of memory plus tag and victim model
    logic [7:0]  shadow [logic [31:0]];
    tag_t        mtag [NUM_SETS][NUM_WAYS];
    bit          mvalid [NUM_SETS][NUM_WAYS];
    bit          mdirty [NUM_SETS][NUM_WAYS];
    way_t        mptr = '0;

    cache_top UUT (
        .clk, .resetn, .req_valid, .req, .addr_ok, .data_ok, .rdata,
        .rd_req, .rd, .rd_rdy, .ret, .wr_req, .wr, .wr_rdy
    );

    cache_tb_mem u_mem (
        .clk, .rd_req, .rd, .rd_rdy, .ret, .wr_req, .wr, .wr_rdy
    );

    always #50 clk = ~clk;

    initial begin
        #(200 * NUM_ACCESSES * 100);
        $display("Watchdog expired: the DUT stopped answering requests");
        $display("Simulation failed");
        $finish;
    end

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = (v << 1) | lfsr[0];
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 16'hB400) : (lfsr >> 1);
        end
        return v;
    endfunction

    function automatic word_t expected_word(input logic [31:0] a);
        word_t w;
        word_t fill;
        logic [31:0] ba;
        fill = {a[31:2], 2'b00} ^ 32'h5A5A0000;
        for (int b = 0; b < 4; b++) begin
            ba = {a[31:2], 2'(b)};
            w[8*b +: 8] = shadow.exists(ba) ? shadow[ba] : fill[8*b +: 8];
        end
        return w;
    endfunction

    function automatic line_t expected_line(input logic [31:0] a);
        line_t l;
        for (int k = 0; k < LINE_WORDS; k++) begin
            l[32*k +: 32] = expected_word({a[31:5], 3'(k), 2'b00});
        end
        return l;
    endfunction

    function automatic cpu_req_t make_req(input logic op, input logic unc,
                                          input logic [31:0] a, input strb_t s, input word_t d);
        return '{op: op, uncached: unc, size: 2'd2, tag: a[31:12], index: a[11:5],
                 offset: a[4:0], wstrb: s, wdata: d};
    endfunction

    task automatic check(input logic [255:0] got, input logic [255:0] exp, input string msg);
        if (got !== exp) begin
            errors++;
            $display("Fail %0t: %s, got %0h, expected %0h", $time, msg, got, exp);
        end
    endtask

    task automatic access(input logic op, input logic unc, input logic [31:0] a,
                          input strb_t s, input word_t d);
        int          rd0;
        int          wr0;
        int          done0;
        int          lat;
        logic        hit_exp;
        logic        wb_exp;
        logic [31:0] wb_addr;
        index_t      idx;
        way_t        v;
        idx = a[11:5];
        rd0 = u_mem.rd_count;
        wr0 = u_mem.wr_count;
        done0 = u_mem.done_count;
        hit_exp = 1'b0;
        wb_exp = 1'b0;
        if (!unc) begin
            for (int w = 0; w < NUM_WAYS; w++) begin
                if (mvalid[idx][w] && mtag[idx][w] == a[31:12]) begin
                    hit_exp = 1'b1;
                    if (op == OP_WRITE) mdirty[idx][w] = 1'b1;
                end
            end
            if (!hit_exp) begin
                v = mptr;
                wb_exp = mvalid[idx][v] && mdirty[idx][v];
                wb_addr = {mtag[idx][v], idx, 5'b0};
                mtag[idx][v] = a[31:12];
                mvalid[idx][v] = 1'b1;
                mdirty[idx][v] = (op == OP_WRITE);
                mptr = ~mptr;
            end
        end
        @(posedge clk);
        #1;
        req = make_req(op, unc, a, s, d);
        req_valid = 1'b1;
        @(negedge clk);
        while (!addr_ok) @(negedge clk);
        @(posedge clk);
        #1;
        req_valid = 1'b0;
        lat = 1;
        @(negedge clk);
        while (!data_ok) begin
            lat++;
            @(negedge clk);
        end
        if (op == OP_READ) check(rdata, expected_word(a), "read data");
        if (op == OP_WRITE || hit_exp) check(lat, 1, "data_ok latency");
        // let a miss finish on the bus before judging its traffic
        if (unc && op == OP_WRITE) begin
            while (u_mem.wr_count == wr0) @(negedge clk);
        end else if (!hit_exp) begin
            while (u_mem.done_count == done0) @(negedge clk);
        end
        check(u_mem.rd_count - rd0, (hit_exp || (unc && op == OP_WRITE)) ? 0 : 1,
              "bus line reads");
        check(u_mem.wr_count - wr0, (wb_exp || (unc && op == OP_WRITE)) ? 1 : 0,
              "bus writes");
        if (u_mem.rd_count > rd0) begin
            check(u_mem.rd_type_log[rd0], unc ? 3'd2 : TYPE_LINE, "read type");
            check(u_mem.rd_addr_log[rd0], unc ? a : {a[31:5], 5'b0}, "read address");
        end
        if (u_mem.wr_count > wr0 && wb_exp) begin
            check(u_mem.wr_type_log[wr0], TYPE_LINE, "writeback type");
            check(u_mem.wr_addr_log[wr0], wb_addr, "writeback address");
            check(u_mem.wr_data_log[wr0], expected_line(wb_addr), "writeback line");
        end else if (u_mem.wr_count > wr0) begin
            check(u_mem.wr_type_log[wr0], 3'd2, "uncached write type");
            check(u_mem.wr_addr_log[wr0], a, "uncached write address");
            check(u_mem.wr_strb_log[wr0], s, "uncached write strobe");
            check(u_mem.wr_data_log[wr0][31:0], d, "uncached write data");
        end
        if (op == OP_WRITE) begin
            for (int b = 0; b < 4; b++) begin
                if (s[b]) shadow[{a[31:2], 2'(b)}] = d[8*b +: 8];
            end
        end
    endtask

    // two hits in a row, the second accepted during the first's data_ok
    task automatic read_pair(input logic [31:0] a1, input logic [31:0] a2);
        int rd0;
        rd0 = u_mem.rd_count;
        @(posedge clk);
        #1;
        req = make_req(OP_READ, 1'b0, a1, '0, '0);
        req_valid = 1'b1;
        @(negedge clk);
        while (!addr_ok) @(negedge clk);
        @(posedge clk);
        #1;
        req = make_req(OP_READ, 1'b0, a2, '0, '0);
        @(negedge clk);
        check(data_ok, 1'b1, "first data_ok of pair");
        check(addr_ok, 1'b1, "second addr_ok in first data_ok cycle");
        check(rdata, expected_word(a1), "first read of pair");
        @(posedge clk);
        #1;
        req_valid = 1'b0;
        @(negedge clk);
        check(data_ok, 1'b1, "second data_ok of pair");
        check(rdata, expected_word(a2), "second read of pair");
        check(u_mem.rd_count - rd0, 0, "bus reads during pair");
    endtask

    initial begin
        logic [31:0] a;
        resetn = 1'b0;
        req_valid = 1'b0;
        req = '0;
        repeat (8) @(posedge clk);
        #1;
        resetn = 1'b1;
        @(negedge clk);
        check({addr_ok, data_ok, rd_req, wr_req}, 4'b0000, "outputs after reset");

        access(OP_READ, 1'b0, 32'h0000_1004, '0, '0);
        access(OP_READ, 1'b0, 32'h0000_100C, '0, '0);

        access(OP_WRITE, 1'b0, 32'h0000_1008, 4'b0101, 32'hA1B2_C3D4);
        access(OP_WRITE, 1'b0, 32'h0000_2010, 4'b1100, 32'h1122_3344);
        access(OP_READ, 1'b0, 32'h0000_1008, '0, '0);
        access(OP_READ, 1'b0, 32'h0000_2010, '0, '0);
        for (int i = 0; i < 6; i++) begin
            a = 32'h0000_1000 + (rand_bits(1) << 13) + (rand_bits(3) << 2);
            access(OP_WRITE, 1'b0, a, strb_t'(rand_bits(4)), rand_bits(32));
            access(OP_READ, 1'b0, a, '0, '0);
        end

        // four tags at set 5, the dirty one is evicted in turn
        access(OP_WRITE, 1'b0, 32'h0001_00A4, 4'b1111, 32'hDEAD_BEEF);
        access(OP_READ, 1'b0, 32'h0002_00A0, '0, '0);
        access(OP_READ, 1'b0, 32'h0003_00A8, '0, '0);
        access(OP_READ, 1'b0, 32'h0004_00AC, '0, '0);
        access(OP_READ, 1'b0, 32'h0001_00A4, '0, '0);

        // set 7 is otherwise untouched, so the line is never cached here
        access(OP_READ, 1'b1, 32'h0000_30E4, '0, '0);
        access(OP_WRITE, 1'b1, 32'h0000_30E8, 4'b0011, 32'h5566_7788);
        access(OP_READ, 1'b0, 32'h0000_30E8, '0, '0);

        read_pair(32'h0000_30E0, 32'h0000_30FC);

        $display("Errors: %0d", errors);
        if (errors == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: project.f
cache_geom_pkg.sv
mem_bus_pkg.sv
cache_tag_store.sv
cache_data_store.sv
cache_refill_buffer.sv
cache_ctrl.sv
cache_top.sv
cache_tb_mem.sv
cache_tb.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= cache_tb
FILELIST  ?= project.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove build output and the log"
	@echo "  help   show this list"

$(BUILD_DIR)/V$(TOP): $(FILELIST) $(shell cat $(FILELIST))
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)

test: $(BUILD_DIR)/V$(TOP)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "Simulation passed" $(LOG) || { echo "test failed, see $(LOG)"; exit 1; }

clean:
	rm -rf $(BUILD_DIR) $(LOG)
